/* udp_oe_csr.f */
common/udp_oe_csr_pkg.sv
hdl/csr_addr_decode.sv
hdl/net_cfg_regs.sv
chan_regs/chan_ctrl_regs.sv
hdl/csr_read_mux.sv
hdl/udp_oe_csr.sv
dv/udp_oe_csr_assert.sv
dv/udp_oe_csr_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the CSR testbench with Verilator, run it and scan the log
rm -rf obj_dir sim.log &&
verilator --binary --assert -Wno-fatal --top-module udp_oe_csr_tb -f udp_oe_csr.f &&
./obj_dir/Vudp_oe_csr_tb > sim.log 2>&1 ||
{ cat sim.log 2>/dev/null; echo "Build or simulation run did not complete"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

/* dv/udp_oe_csr_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the CSR block
// Bus tasks, compare tasks, watchdog and summary
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module udp_oe_csr_tb;

    localparam int TEST_CYCLES = 300; // About 85 bus operations of up to 3 cycles

    logic                       uoe_csr_avmm;
    logic                       rst_local;
    udp_oe_csr_pkg::csr_req_t   csr_req;
    udp_oe_csr_pkg::csr_rsp_t   csr_rsp;
    udp_oe_csr_pkg::net_cfg_t   net_cfg;
    udp_oe_csr_pkg::chan_ctrl_t chan_ctrl [udp_oe_csr_pkg::NUM_CHAN];
    udp_oe_csr_pkg::chan_sts_t  chan_sts  [udp_oe_csr_pkg::NUM_CHAN];

    udp_oe_csr_pkg::net_cfg_t   exp_cfg; // Model of the shared settings
    udp_oe_csr_pkg::csr_word_t  exp_scratch;
    udp_oe_csr_pkg::chan_ctrl_t exp_ctrl [udp_oe_csr_pkg::NUM_CHAN];
    integer seed;
    int     value_errs;
    int     resp_errs;

    udp_oe_csr dut (
        .uoe_csr_avmm (uoe_csr_avmm),
        .rst_local    (rst_local),
        .csr_req      (csr_req),
        .csr_rsp      (csr_rsp),
        .net_cfg      (net_cfg),
        .chan_ctrl    (chan_ctrl),
        .chan_sts     (chan_sts)
    );

    always #20 uoe_csr_avmm = ~uoe_csr_avmm;

    function automatic udp_oe_csr_pkg::csr_word_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic check_word(input string name, input udp_oe_csr_pkg::csr_word_t got,
                              input udp_oe_csr_pkg::csr_word_t exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_net_cfg(input udp_oe_csr_pkg::net_cfg_t got,
                                 input udp_oe_csr_pkg::net_cfg_t exp);
        if (got !== exp) begin
            $display("Error: net_cfg got %h expected %h", got, exp);
            value_errs++;
        end
    endtask

    task automatic check_chan_ctrl(input string name, input udp_oe_csr_pkg::chan_ctrl_t got,
                                   input udp_oe_csr_pkg::chan_ctrl_t exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic compare_all_ctrl();
        for (int c = 0; c < udp_oe_csr_pkg::NUM_CHAN; c++)
            check_chan_ctrl($sformatf("chan_ctrl[%0d]", c), chan_ctrl[c], exp_ctrl[c]);
    endtask

    task automatic do_write(input udp_oe_csr_pkg::word_addr_t a,
                            input udp_oe_csr_pkg::csr_word_t d);
        @(negedge uoe_csr_avmm);
        csr_req.address   = {a, 3'b000};
        csr_req.write     = 1'b1;
        csr_req.writedata = d;
        @(negedge uoe_csr_avmm);
        csr_req.write = 1'b0;
    endtask

    task automatic do_read(input udp_oe_csr_pkg::word_addr_t a,
                           output udp_oe_csr_pkg::csr_word_t d);
        int wait_cnt;
        @(negedge uoe_csr_avmm);
        csr_req.address = {a, 3'b000};
        csr_req.read    = 1'b1;
        @(negedge uoe_csr_avmm);
        csr_req.read = 1'b0;
        wait_cnt = 0;
        while (!csr_rsp.readdatavalid && wait_cnt < 4) begin
            @(negedge uoe_csr_avmm);
            wait_cnt++;
        end
        d = csr_rsp.readdata;
        if (!csr_rsp.readdatavalid) begin
            $display("Read of word address %h got no readdatavalid", a);
            resp_errs++;
        end
    endtask

    task automatic read_expect(input udp_oe_csr_pkg::word_addr_t a,
                               input udp_oe_csr_pkg::csr_word_t exp);
        udp_oe_csr_pkg::csr_word_t d;
        do_read(a, d);
        check_word($sformatf("readdata @%h", a), d, exp);
    endtask

    // Readback of a network register, zero-extended to 64 bits
    function automatic udp_oe_csr_pkg::csr_word_t net_word(input udp_oe_csr_pkg::word_addr_t a);
        case (a)
            10'h10:  return {16'h0, exp_cfg.fpga_mac_adr};
            10'h11:  return {32'h0, exp_cfg.fpga_ip_adr};
            10'h12:  return {48'h0, exp_cfg.fpga_udp_port};
            10'h13:  return {32'h0, exp_cfg.fpga_netmask};
            10'h14:  return {16'h0, exp_cfg.host_mac_adr};
            10'h15:  return {32'h0, exp_cfg.host_ip_adr};
            10'h16:  return {48'h0, exp_cfg.host_udp_port};
            10'h17:  return {48'h0, exp_cfg.payload_per_packet};
            default: return {48'h0, exp_cfg.checksum_ip};
        endcase
    endfunction

    task automatic model_net_write(input udp_oe_csr_pkg::word_addr_t a,
                                   input udp_oe_csr_pkg::csr_word_t d);
        case (a)
            10'h10:  exp_cfg.fpga_mac_adr       = d[47:0];
            10'h11:  exp_cfg.fpga_ip_adr        = d[31:0];
            10'h12:  exp_cfg.fpga_udp_port      = d[15:0];
            10'h13:  exp_cfg.fpga_netmask       = d[31:0];
            10'h14:  exp_cfg.host_mac_adr       = d[47:0];
            10'h15:  exp_cfg.host_ip_adr        = d[31:0];
            10'h16:  exp_cfg.host_udp_port      = d[15:0];
            10'h17:  exp_cfg.payload_per_packet = d[15:0];
            default: exp_cfg.checksum_ip        = d[15:0];
        endcase
    endtask

    task automatic reset_values();
        exp_cfg = '0;
        exp_cfg.payload_per_packet = 16'h0400;
        exp_scratch = '0;
        for (int c = 0; c < udp_oe_csr_pkg::NUM_CHAN; c++)
            exp_ctrl[c] = '0;
        check_net_cfg(net_cfg, exp_cfg);
        compare_all_ctrl();
        read_expect(10'h05, exp_scratch);
        for (int a = 'h10; a <= 'h18; a++)
            read_expect(10'(a), net_word(10'(a)));
    endtask

    task automatic feature_header_reads();
        read_expect(10'h00, udp_oe_csr_pkg::DFH_HEADER_WORD);
        read_expect(10'h01, udp_oe_csr_pkg::DFH_ID_LO);
        read_expect(10'h02, udp_oe_csr_pkg::DFH_ID_HI);
        read_expect(10'h03, udp_oe_csr_pkg::DFH_ADDR_OFFSET_WORD);
        read_expect(10'h04, udp_oe_csr_pkg::DFH_REGSZ_WORD);
        read_expect(10'h06, 64'd4);
    endtask

    task automatic net_register_writes();
        udp_oe_csr_pkg::csr_word_t d;
        exp_scratch = rand64();
        do_write(10'h05, exp_scratch);
        read_expect(10'h05, exp_scratch);
        for (int a = 'h10; a <= 'h18; a++) begin
            d = rand64();
            do_write(10'(a), d);
            model_net_write(10'(a), d);
            check_net_cfg(net_cfg, exp_cfg);
            read_expect(10'(a), net_word(10'(a)));
        end
    endtask

    task automatic channel_windows();
        udp_oe_csr_pkg::word_addr_t base;
        udp_oe_csr_pkg::csr_word_t  d;
        for (int c = 0; c < udp_oe_csr_pkg::NUM_CHAN; c++) begin
            base = 10'(32'h20 + c * 8);
            d = rand64();
            d[1:0] = 2'(c % 3 + 1); // Reset bits step through 01, 10, 11, 01
            do_write(base + 10'd1, d);
            exp_ctrl[c].tx_rst = d[1];
            exp_ctrl[c].rx_rst = d[0];
            compare_all_ctrl();
            read_expect(base + 10'd1, {62'h0, d[1:0]});
            read_expect(base, (64'(c) << 8) + 64'h10);
            read_expect(base + 10'd2, {chan_sts[c].tx_status, chan_sts[c].rx_status});
            for (int off = 4; off < 8; off++)
                read_expect(base + 10'(off), 64'h0);
        end
    endtask

    task automatic shared_misc();
        exp_cfg.misc_ctrl = rand64();
        do_write(10'h33, exp_cfg.misc_ctrl); // Channel 2 window
        check_net_cfg(net_cfg, exp_cfg);
        for (int c = 0; c < udp_oe_csr_pkg::NUM_CHAN; c++)
            read_expect(10'(32'h23 + c * 8), exp_cfg.misc_ctrl);
    endtask

    task automatic unmapped_addresses();
        udp_oe_csr_pkg::word_addr_t bad [4] = '{10'h07, 10'h19, 10'h40, 10'h3FF};
        for (int i = 0; i < 4; i++) begin
            read_expect(bad[i], 64'h0BAD_0BAD_0BAD_0BAD);
            do_write(bad[i], rand64());
            check_net_cfg(net_cfg, exp_cfg);
            compare_all_ctrl();
        end
        read_expect(10'h05, exp_scratch);
    endtask

    initial begin
        #(TEST_CYCLES * 40 + 4000);
        $display("Watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        seed         = 32'h24de_f620;
        value_errs   = 0;
        resp_errs    = 0;
        uoe_csr_avmm = 1'b0;
        rst_local    = 1'b1;
        csr_req      = '0;
        for (int c = 0; c < udp_oe_csr_pkg::NUM_CHAN; c++)
            chan_sts[c] = {$random(seed), $random(seed)};
        repeat (8) @(negedge uoe_csr_avmm);
        rst_local = 1'b0;
        reset_values();
        feature_header_reads();
        net_register_writes();
        channel_windows();
        shared_misc();
        unmapped_addresses();
        $display("Value errors: %0d, missing responses: %0d", value_errs, resp_errs);
        if (value_errs == 0 && resp_errs == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/udp_oe_csr_assert.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read response timing assertions, bound to the CSR top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module udp_oe_csr_assert (
    input logic                     uoe_csr_avmm,
    input logic                     rst_local,
    input udp_oe_csr_pkg::csr_req_t csr_req,
    input udp_oe_csr_pkg::csr_rsp_t csr_rsp
);

    // Every read gets its valid pulse on the next cycle
    rd_followed_by_valid: assert property (@(posedge uoe_csr_avmm) disable iff (rst_local)
        csr_req.read |=> csr_rsp.readdatavalid)
        else $error("readdatavalid missing one cycle after a read");

    rd_valid_has_read: assert property (@(posedge uoe_csr_avmm) disable iff (rst_local)
        csr_rsp.readdatavalid |-> $past(csr_req.read))
        else $error("readdatavalid without a read one cycle earlier");

    // Reset is synchronous, so valid clears one edge later
    rd_valid_low_in_reset: assert property (@(posedge uoe_csr_avmm)
        rst_local |=> !csr_rsp.readdatavalid)
        else $error("readdatavalid high during reset");

endmodule

bind udp_oe_csr udp_oe_csr_assert u_assert (
    .uoe_csr_avmm (uoe_csr_avmm),
    .rst_local    (rst_local),
    .csr_req      (csr_req),
    .csr_rsp      (csr_rsp)
);

`default_nettype wire

/* hdl/udp_oe_csr.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CSR block top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module udp_oe_csr (
    input  logic                      uoe_csr_avmm,
    input  logic                      rst_local,
    input  udp_oe_csr_pkg::csr_req_t  csr_req,
    output udp_oe_csr_pkg::csr_rsp_t  csr_rsp,
    output udp_oe_csr_pkg::net_cfg_t  net_cfg,
    output udp_oe_csr_pkg::chan_ctrl_t chan_ctrl [udp_oe_csr_pkg::NUM_CHAN],
    input  udp_oe_csr_pkg::chan_sts_t chan_sts  [udp_oe_csr_pkg::NUM_CHAN]
);

    udp_oe_csr_pkg::csr_sel_t  sel;
    udp_oe_csr_pkg::csr_word_t scratchpad;
    udp_oe_csr_pkg::csr_word_t chan_rdata;

    csr_addr_decode u_decode (
        .address (csr_req.address),
        .sel     (sel)
    );

    net_cfg_regs u_net_cfg (
        .uoe_csr_avmm (uoe_csr_avmm),
        .rst_local    (rst_local),
        .write        (csr_req.write),
        .writedata    (csr_req.writedata),
        .sel          (sel),
        .net_cfg      (net_cfg),
        .scratchpad   (scratchpad)
    );

    chan_ctrl_regs u_chan (
        .uoe_csr_avmm (uoe_csr_avmm),
        .rst_local    (rst_local),
        .write        (csr_req.write),
        .writedata    (csr_req.writedata),
        .sel          (sel),
        .chan_sts     (chan_sts),
        .chan_ctrl    (chan_ctrl),
        .chan_rdata   (chan_rdata)
    );

    csr_read_mux u_rd_mux (
        .uoe_csr_avmm (uoe_csr_avmm),
        .rst_local    (rst_local),
        .read         (csr_req.read),
        .sel          (sel),
        .net_cfg      (net_cfg),
        .scratchpad   (scratchpad),
        .chan_rdata   (chan_rdata),
        .csr_rsp      (csr_rsp)
    );

endmodule

`default_nettype wire

/* hdl/csr_read_mux.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Registered read data and read-valid
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module csr_read_mux (
    input  logic                      uoe_csr_avmm,
    input  logic                      rst_local,
    input  logic                      read,
    input  udp_oe_csr_pkg::csr_sel_t  sel,
    input  udp_oe_csr_pkg::net_cfg_t  net_cfg,
    input  udp_oe_csr_pkg::csr_word_t scratchpad,
    input  udp_oe_csr_pkg::csr_word_t chan_rdata,
    output udp_oe_csr_pkg::csr_rsp_t  csr_rsp
);

    udp_oe_csr_pkg::csr_word_t rd_word;

    // Word picked by the decoded register, narrow fields zero-extended
    always_comb begin
        case (sel.reg_id)
            udp_oe_csr_pkg::REG_DFH_HEADER:      rd_word = udp_oe_csr_pkg::DFH_HEADER_WORD;
            udp_oe_csr_pkg::REG_DFH_ID_LO:       rd_word = udp_oe_csr_pkg::DFH_ID_LO;
            udp_oe_csr_pkg::REG_DFH_ID_HI:       rd_word = udp_oe_csr_pkg::DFH_ID_HI;
            udp_oe_csr_pkg::REG_DFH_ADDR_OFFSET: rd_word = udp_oe_csr_pkg::DFH_ADDR_OFFSET_WORD;
            udp_oe_csr_pkg::REG_DFH_REGSZ:       rd_word = udp_oe_csr_pkg::DFH_REGSZ_WORD;
            udp_oe_csr_pkg::REG_SCRATCHPAD:      rd_word = scratchpad;
            udp_oe_csr_pkg::REG_NUM_CHANNELS:    rd_word = 64'(udp_oe_csr_pkg::NUM_CHAN);
            udp_oe_csr_pkg::REG_FPGA_MAC:        rd_word = {16'h0, net_cfg.fpga_mac_adr};
            udp_oe_csr_pkg::REG_FPGA_IP:         rd_word = {32'h0, net_cfg.fpga_ip_adr};
            udp_oe_csr_pkg::REG_FPGA_UDP_PORT:   rd_word = {48'h0, net_cfg.fpga_udp_port};
            udp_oe_csr_pkg::REG_FPGA_NETMASK:    rd_word = {32'h0, net_cfg.fpga_netmask};
            udp_oe_csr_pkg::REG_HOST_MAC:        rd_word = {16'h0, net_cfg.host_mac_adr};
            udp_oe_csr_pkg::REG_HOST_IP:         rd_word = {32'h0, net_cfg.host_ip_adr};
            udp_oe_csr_pkg::REG_HOST_UDP_PORT:   rd_word = {48'h0, net_cfg.host_udp_port};
            udp_oe_csr_pkg::REG_PAYLOAD_PER_PACKET:
                rd_word = {48'h0, net_cfg.payload_per_packet};
            udp_oe_csr_pkg::REG_CHECKSUM_IP:     rd_word = {48'h0, net_cfg.checksum_ip};
            udp_oe_csr_pkg::CHAN_MISC:           rd_word = net_cfg.misc_ctrl;
            udp_oe_csr_pkg::CHAN_RESET,
            udp_oe_csr_pkg::CHAN_OTHER:          rd_word = chan_rdata;
            default:                             rd_word = udp_oe_csr_pkg::REG_RD_BADADDR_DATA;
        endcase
    end

    always_ff @(posedge uoe_csr_avmm) begin
        if (rst_local) begin
            csr_rsp <= '0;
        end else begin
            csr_rsp.readdatavalid <= read; // One pulse per read strobe
            if (read)
                csr_rsp.readdata <= rd_word; // Value before this edge's write
        end
    end

endmodule

`default_nettype wire

/* chan_regs/chan_ctrl_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Per-channel reset bits and channel read words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module chan_ctrl_regs (
    input  logic                       uoe_csr_avmm,
    input  logic                       rst_local,
    input  logic                       write,
    input  udp_oe_csr_pkg::csr_word_t  writedata,
    input  udp_oe_csr_pkg::csr_sel_t   sel,
    input  udp_oe_csr_pkg::chan_sts_t  chan_sts  [udp_oe_csr_pkg::NUM_CHAN],
    output udp_oe_csr_pkg::chan_ctrl_t chan_ctrl [udp_oe_csr_pkg::NUM_CHAN],
    output udp_oe_csr_pkg::csr_word_t  chan_rdata
);

    udp_oe_csr_pkg::chan_ctrl_t cur_ctrl;
    udp_oe_csr_pkg::chan_sts_t  cur_sts;

    for (genvar c = 0; c < udp_oe_csr_pkg::NUM_CHAN; c++) begin : g_chan
        always_ff @(posedge uoe_csr_avmm) begin
            if (rst_local) begin
                chan_ctrl[c] <= '0;
            end else if (write && sel.reg_id == udp_oe_csr_pkg::CHAN_RESET &&
                         sel.chan_idx == udp_oe_csr_pkg::CHAN_IDX_W'(c)) begin
                chan_ctrl[c].tx_rst <= writedata[1];
                chan_ctrl[c].rx_rst <= writedata[0];
            end
        end
    end

    // Slot selected by the decoded channel index
    assign cur_ctrl = chan_ctrl[sel.chan_idx];
    assign cur_sts  = chan_sts[sel.chan_idx];

    always_comb begin
        case (sel.chan_off)
            udp_oe_csr_pkg::CHAN_INFO_OFF:
                chan_rdata = {48'h0, 8'(sel.chan_idx), udp_oe_csr_pkg::CHAN_INFO_TAG};
            udp_oe_csr_pkg::CHAN_RESET_OFF:
                chan_rdata = {62'h0, cur_ctrl.tx_rst, cur_ctrl.rx_rst};
            udp_oe_csr_pkg::CHAN_STATUS_OFF:
                chan_rdata = {cur_sts.tx_status, cur_sts.rx_status};
            default:
                chan_rdata = '0; // Misc comes from net_cfg, the rest are spare
        endcase
    end

endmodule

`default_nettype wire

/* hdl/net_cfg_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scratchpad, shared network settings and misc control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module net_cfg_regs (
    input  logic                      uoe_csr_avmm,
    input  logic                      rst_local,
    input  logic                      write,
    input  udp_oe_csr_pkg::csr_word_t writedata,
    input  udp_oe_csr_pkg::csr_sel_t  sel,
    output udp_oe_csr_pkg::net_cfg_t  net_cfg,
    output udp_oe_csr_pkg::csr_word_t scratchpad
);

    always_ff @(posedge uoe_csr_avmm) begin
        if (rst_local) begin
            net_cfg                    <= '0;
            net_cfg.payload_per_packet <= udp_oe_csr_pkg::DEFAULT_PAYLOAD_PER_PACKET;
            scratchpad                 <= '0;
        end else if (write) begin
            // Only the field width is taken from writedata
            case (sel.reg_id)
                udp_oe_csr_pkg::REG_SCRATCHPAD:
                    scratchpad <= writedata;
                udp_oe_csr_pkg::REG_FPGA_MAC:
                    net_cfg.fpga_mac_adr <= writedata[47:0];
                udp_oe_csr_pkg::REG_FPGA_IP:
                    net_cfg.fpga_ip_adr <= writedata[31:0];
                udp_oe_csr_pkg::REG_FPGA_UDP_PORT:
                    net_cfg.fpga_udp_port <= writedata[15:0];
                udp_oe_csr_pkg::REG_FPGA_NETMASK:
                    net_cfg.fpga_netmask <= writedata[31:0];
                udp_oe_csr_pkg::REG_HOST_MAC:
                    net_cfg.host_mac_adr <= writedata[47:0];
                udp_oe_csr_pkg::REG_HOST_IP:
                    net_cfg.host_ip_adr <= writedata[31:0];
                udp_oe_csr_pkg::REG_HOST_UDP_PORT:
                    net_cfg.host_udp_port <= writedata[15:0];
                udp_oe_csr_pkg::REG_PAYLOAD_PER_PACKET:
                    net_cfg.payload_per_packet <= writedata[15:0];
                udp_oe_csr_pkg::REG_CHECKSUM_IP:
                    net_cfg.checksum_ip <= writedata[15:0];
                udp_oe_csr_pkg::CHAN_MISC:
                    net_cfg.misc_ctrl <= writedata; // Shared by every channel window
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/csr_addr_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Byte address to register id and channel slot
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module csr_addr_decode (
    input  udp_oe_csr_pkg::byte_addr_t address,
    output udp_oe_csr_pkg::csr_sel_t   sel
);

    udp_oe_csr_pkg::word_addr_t word_addr;
    udp_oe_csr_pkg::word_addr_t chan_rel;

    assign word_addr = address[12:3]; // Accesses are full 64-bit words
    assign chan_rel  = word_addr - udp_oe_csr_pkg::CHAN_BASE_ADDR;

    always_comb begin
        sel.chan_idx = '0;
        sel.chan_off = '0;
        case (word_addr)
            udp_oe_csr_pkg::DFH_HEADER_ADDR:          sel.reg_id = udp_oe_csr_pkg::REG_DFH_HEADER;
            udp_oe_csr_pkg::DFH_ID_LO_ADDR:           sel.reg_id = udp_oe_csr_pkg::REG_DFH_ID_LO;
            udp_oe_csr_pkg::DFH_ID_HI_ADDR:           sel.reg_id = udp_oe_csr_pkg::REG_DFH_ID_HI;
            udp_oe_csr_pkg::DFH_REG_ADDR_OFFSET_ADDR:
                sel.reg_id = udp_oe_csr_pkg::REG_DFH_ADDR_OFFSET;
            udp_oe_csr_pkg::DFH_REGSZ_ADDR:           sel.reg_id = udp_oe_csr_pkg::REG_DFH_REGSZ;
            udp_oe_csr_pkg::SCRATCHPAD_ADDR:          sel.reg_id = udp_oe_csr_pkg::REG_SCRATCHPAD;
            udp_oe_csr_pkg::NUM_CHANNELS_ADDR:        sel.reg_id = udp_oe_csr_pkg::REG_NUM_CHANNELS;
            udp_oe_csr_pkg::FPGA_MAC_ADDR:            sel.reg_id = udp_oe_csr_pkg::REG_FPGA_MAC;
            udp_oe_csr_pkg::FPGA_IP_ADDR:             sel.reg_id = udp_oe_csr_pkg::REG_FPGA_IP;
            udp_oe_csr_pkg::FPGA_UDP_PORT_ADDR:       sel.reg_id = udp_oe_csr_pkg::REG_FPGA_UDP_PORT;
            udp_oe_csr_pkg::FPGA_NETMASK_ADDR:        sel.reg_id = udp_oe_csr_pkg::REG_FPGA_NETMASK;
            udp_oe_csr_pkg::HOST_MAC_ADDR:            sel.reg_id = udp_oe_csr_pkg::REG_HOST_MAC;
            udp_oe_csr_pkg::HOST_IP_ADDR:             sel.reg_id = udp_oe_csr_pkg::REG_HOST_IP;
            udp_oe_csr_pkg::HOST_UDP_PORT_ADDR:       sel.reg_id = udp_oe_csr_pkg::REG_HOST_UDP_PORT;
            udp_oe_csr_pkg::PAYLOAD_PER_PACKET_ADDR:
                sel.reg_id = udp_oe_csr_pkg::REG_PAYLOAD_PER_PACKET;
            udp_oe_csr_pkg::CHECKSUM_IP_ADDR:         sel.reg_id = udp_oe_csr_pkg::REG_CHECKSUM_IP;
            default: begin
                if (word_addr >= udp_oe_csr_pkg::CHAN_BASE_ADDR &&
                    word_addr <= udp_oe_csr_pkg::CHAN_END_ADDR) begin
                    // Window index above the 8-word offset
                    sel.chan_idx = chan_rel[udp_oe_csr_pkg::CHAN_IDX_W+2:3];
                    sel.chan_off = chan_rel[2:0];
                    if (chan_rel[2:0] == udp_oe_csr_pkg::CHAN_RESET_OFF)
                        sel.reg_id = udp_oe_csr_pkg::CHAN_RESET;
                    else if (chan_rel[2:0] == udp_oe_csr_pkg::CHAN_MISC_OFF)
                        sel.reg_id = udp_oe_csr_pkg::CHAN_MISC;
                    else
                        sel.reg_id = udp_oe_csr_pkg::CHAN_OTHER;
                end else begin
                    sel.reg_id = udp_oe_csr_pkg::BAD_ADDR;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

/* common/udp_oe_csr_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UDP offload engine CSR package
// Address map, feature header, widths and bus structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package udp_oe_csr_pkg;

    localparam int NUM_CHAN             = 4;
    localparam int CSR_ADDR_PER_CHANNEL = 8;
    localparam int CHAN_IDX_W           = 2;

    typedef logic [63:0] csr_word_t;
    typedef logic [12:0] byte_addr_t;
    typedef logic [9:0]  word_addr_t;
    typedef logic [47:0] mac_adr_t;
    typedef logic [31:0] ip_adr_t;
    typedef logic [15:0] half_t;

    // Word addresses of the common registers
    localparam word_addr_t DFH_HEADER_ADDR          = 10'h00;
    localparam word_addr_t DFH_ID_LO_ADDR           = 10'h01;
    localparam word_addr_t DFH_ID_HI_ADDR           = 10'h02;
    localparam word_addr_t DFH_REG_ADDR_OFFSET_ADDR = 10'h03;
    localparam word_addr_t DFH_REGSZ_ADDR           = 10'h04;
    localparam word_addr_t SCRATCHPAD_ADDR          = 10'h05;
    localparam word_addr_t NUM_CHANNELS_ADDR        = 10'h06;
    localparam word_addr_t FPGA_MAC_ADDR            = 10'h10;
    localparam word_addr_t FPGA_IP_ADDR             = 10'h11;
    localparam word_addr_t FPGA_UDP_PORT_ADDR       = 10'h12;
    localparam word_addr_t FPGA_NETMASK_ADDR        = 10'h13;
    localparam word_addr_t HOST_MAC_ADDR            = 10'h14;
    localparam word_addr_t HOST_IP_ADDR             = 10'h15;
    localparam word_addr_t HOST_UDP_PORT_ADDR       = 10'h16;
    localparam word_addr_t PAYLOAD_PER_PACKET_ADDR  = 10'h17;
    localparam word_addr_t CHECKSUM_IP_ADDR         = 10'h18;
    localparam word_addr_t CHAN_BASE_ADDR           = 10'h20;
    localparam word_addr_t CHAN_END_ADDR            =
        CHAN_BASE_ADDR + word_addr_t'(NUM_CHAN * CSR_ADDR_PER_CHANNEL) - 10'd1;

    // Offsets inside one channel window
    localparam logic [2:0] CHAN_INFO_OFF      = 3'd0;
    localparam logic [2:0] CHAN_RESET_OFF     = 3'd1;
    localparam logic [2:0] CHAN_STATUS_OFF    = 3'd2;
    localparam logic [2:0] CHAN_MISC_OFF      = 3'd3;
    localparam logic [2:0] CHAN_TX_STATUS_OFF = 3'd4;
    localparam logic [2:0] CHAN_RX_STATUS_OFF = 3'd5;
    localparam logic [7:0] CHAN_INFO_TAG      = 8'h10;

    // Feature header fields
    localparam logic [3:0]  DFH_HDR_FTYPE       = 4'h1; // Private feature
    localparam logic [7:0]  DFH_HDR_VER         = 8'h01;
    localparam logic [10:0] DFH_HDR_RSVD0       = 11'h0;
    localparam logic        DFH_HDR_EOL         = 1'b1; // Last in list
    localparam logic [23:0] DFH_HDR_NEXT_DFH    = 24'h0;
    localparam logic [3:0]  DFH_HDR_FEATURE_REV = 4'h0;
    localparam logic [11:0] DFH_HDR_FEATURE_ID  = 12'h0;
    localparam logic [62:0] DFH_REG_ADDR_OFFSET = 63'h28;
    localparam logic        DFH_REL             = 1'b1;
    localparam logic [31:0] DFH_REG_SZ          = 32'h200; // Bytes of register space
    localparam logic        DFH_PARAMS          = 1'b0;
    localparam logic [14:0] DFH_GROUP           = 15'h0;
    localparam logic [15:0] DFH_INSTANCE        = 16'h0;

    localparam csr_word_t DFH_HEADER_WORD = {DFH_HDR_FTYPE, DFH_HDR_VER, DFH_HDR_RSVD0,
        DFH_HDR_EOL, DFH_HDR_NEXT_DFH, DFH_HDR_FEATURE_REV, DFH_HDR_FEATURE_ID};
    localparam csr_word_t DFH_ID_LO           = 64'hB9A7_5C3E_1F42_8D06;
    localparam csr_word_t DFH_ID_HI           = 64'h4E21_93D7_A6C8_05F1;
    localparam csr_word_t DFH_ADDR_OFFSET_WORD = {DFH_REG_ADDR_OFFSET, DFH_REL};
    localparam csr_word_t DFH_REGSZ_WORD = {DFH_REG_SZ, DFH_PARAMS, DFH_GROUP, DFH_INSTANCE};

    localparam half_t     DEFAULT_PAYLOAD_PER_PACKET = 16'h0400;
    localparam csr_word_t REG_RD_BADADDR_DATA        = 64'h0BAD_0BAD_0BAD_0BAD;

    typedef struct packed {
        byte_addr_t address;
        logic       read;
        logic       write;
        csr_word_t  writedata;
    } csr_req_t;

    typedef struct packed {
        csr_word_t readdata;
        logic      readdatavalid;
    } csr_rsp_t;

    typedef enum logic [4:0] {
        REG_DFH_HEADER, REG_DFH_ID_LO, REG_DFH_ID_HI, REG_DFH_ADDR_OFFSET, REG_DFH_REGSZ,
        REG_SCRATCHPAD, REG_NUM_CHANNELS,
        REG_FPGA_MAC, REG_FPGA_IP, REG_FPGA_UDP_PORT, REG_FPGA_NETMASK,
        REG_HOST_MAC, REG_HOST_IP, REG_HOST_UDP_PORT,
        REG_PAYLOAD_PER_PACKET, REG_CHECKSUM_IP,
        CHAN_RESET, CHAN_MISC, CHAN_OTHER, BAD_ADDR
    } csr_reg_e;

    typedef struct packed {
        csr_reg_e              reg_id;
        logic [CHAN_IDX_W-1:0] chan_idx;
        logic [2:0]            chan_off;
    } csr_sel_t;

    typedef struct packed {
        mac_adr_t  fpga_mac_adr;
        ip_adr_t   fpga_ip_adr;
        half_t     fpga_udp_port;
        ip_adr_t   fpga_netmask;
        mac_adr_t  host_mac_adr;
        ip_adr_t   host_ip_adr;
        half_t     host_udp_port;
        half_t     payload_per_packet;
        half_t     checksum_ip;
        csr_word_t misc_ctrl;
    } net_cfg_t;

    typedef struct packed {
        logic tx_rst;
        logic rx_rst;
    } chan_ctrl_t;

    typedef struct packed {
        logic [31:0] tx_status;
        logic [31:0] rx_status;
    } chan_sts_t;

endpackage

`default_nettype wire
